// ==== flist.f ====
+incdir+logic
logic/img_tx_pkg.sv
logic/scan_ctrl_if.sv
logic/frame_buffer.sv
logic/pixel_addr_counter.sv
logic/send_img_fsm.sv
logic/uart_tx.sv
logic/img_tx_top.sv
bench/img_tx_tb.sv

// ==== Makefile ====
TOP := img_tx_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

# pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir

// ==== bench/img_tx_tb.sv ====
`timescale 1ns/1ps
`include "img_tx_settings.svh"

module img_tx_tb;

  localparam int FRAME_CYCLES = 10 * `CLOCKS_PER_BAUD;
  localparam int GAP_LIMIT    = 4 * FRAME_CYCLES; // longest wait for a start bit

  logic               clk;
  logic               rst_in;
  logic               wr_en;
  logic [`ADDR_W-1:0] wr_addr;
  logic [7:0]         wr_data;
  logic               img_ready;
  logic               tx;
  logic               busy;
  logic [1:0]         out_state;

  logic [7:0] ref_img [`IMG_PIXELS]; // expected line bytes in address order
  integer     seed = 32'h085146b7;
  int         error_count = 0;
  int         timeout_count = 0;

  img_tx_top img_tx_inst (
    .clk       (clk),
    .rst_in    (rst_in),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .img_ready (img_ready),
    .tx        (tx),
    .busy      (busy),
    .out_state (out_state)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic log_mismatch(input string msg);
    error_count++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic log_timeout(input string msg);
    timeout_count++;
    $display("TIMEOUT at %0t: %s", $time, msg);
  endtask

  task automatic write_byte(input int a, input logic [7:0] d);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= a[`ADDR_W-1:0];
    wr_data <= d;
    @(posedge clk);
    wr_en   <= 1'b0;
  endtask

  // kind 0 ramp, 1 alternating bits, anything else random
  task automatic load_image(input int kind);
    int         i;
    logic [7:0] d;
    for (i = 0; i < `IMG_PIXELS; i++) begin
      case (kind)
        0:       d = 8'(i * 17) ^ 8'(i >> 8);
        1:       d = 8'(i >> 1) ^ ((i % 2 == 0) ? 8'h55 : 8'hAA);
        default: d = 8'($random(seed));
      endcase
      ref_img[i] = d;
      write_byte(i, d);
    end
  endtask

  task automatic start_send();
    @(posedge clk);
    img_ready <= 1'b1;
    @(posedge clk);
    img_ready <= 1'b0;
  endtask

  task automatic wait_busy_level(input logic level, input int limit, input string what);
    int waited;
    waited = 0;
    while (busy !== level && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (busy !== level) begin
      log_timeout($sformatf("%s: busy never went to %0d", what, level));
    end
  endtask

  // samples every cycle of one frame on the falling clock edge
  task automatic decode_frame(input bit in_image, output logic [7:0] value, output bit found);
    logic [FRAME_CYCLES-1:0] line;
    logic                    mid;
    int                      waited;
    int                      b;
    int                      k;
    value  = '0;
    found  = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (in_image) begin
        assert (busy === 1'b1 && (out_state == 2'd1 || out_state == 2'd2)) else
          log_mismatch($sformatf("between frames: busy %b out_state %0d", busy, out_state));
      end else begin
        assert (busy === 1'b0 && out_state === 2'd0) else
          log_mismatch($sformatf("after the image: busy %b out_state %0d", busy, out_state));
      end
    end while (tx !== 1'b0 && waited < GAP_LIMIT);
    if (tx !== 1'b0) begin
      return; // line stayed idle
    end
    found = 1'b1;
    for (k = 0; k < FRAME_CYCLES; k++) begin
      if (k > 0) begin
        @(negedge clk);
      end
      line[k] = tx;
      assert (out_state == 2'd2) else
        log_mismatch($sformatf("out_state %0d during frame cycle %0d", out_state, k));
    end
    // every bit must hold its level for a whole baud period
    for (b = 0; b < 10; b++) begin
      mid = line[b * `CLOCKS_PER_BAUD + `CLOCKS_PER_BAUD / 2];
      for (k = 0; k < `CLOCKS_PER_BAUD; k++) begin
        assert (line[b * `CLOCKS_PER_BAUD + k] === mid) else
          log_mismatch($sformatf("frame bit %0d changed at cycle %0d of its period", b, k));
      end
      if (b >= 1 && b <= 8) begin
        value[b - 1] = mid; // LSB first
      end
    end
    assert (line[`CLOCKS_PER_BAUD / 2] === 1'b0) else
      log_mismatch("start bit is not low");
    assert (line[9 * `CLOCKS_PER_BAUD + `CLOCKS_PER_BAUD / 2] === 1'b1) else
      log_mismatch("stop bit is not high");
  endtask

  task automatic receive_image(input string label, input bit check_idle);
    logic [7:0] value;
    bit         found;
    int         i;
    for (i = 0; i < `IMG_PIXELS; i++) begin
      decode_frame(1'b1, value, found);
      if (!found) begin
        log_timeout($sformatf("%s: no start bit for pixel %0d", label, i));
        return;
      end
      assert (value === ref_img[i]) else
        log_mismatch($sformatf("%s: pixel %0d got %02h, expected %02h",
                               label, i, value, ref_img[i]));
    end
    assert (busy === 1'b1) else
      log_mismatch($sformatf("%s: busy fell before the last stop bit ended", label));
    wait_busy_level(1'b0, 2 * `CLOCKS_PER_BAUD, label);
    if (check_idle) begin
      decode_frame(1'b0, value, found); // nothing may follow the last pixel
      assert (!found) else
        log_mismatch($sformatf("%s: extra frame after the last pixel", label));
    end
  endtask

  task automatic overwrite_while_busy();
    int a;
    wait_busy_level(1'b1, 16, "overwrite");
    for (a = 0; a < `IMG_PIXELS; a++) begin
      write_byte(a, ~ref_img[a]);
    end
  endtask

  task automatic pulse_ready_while_busy(input int pulses);
    int n;
    wait_busy_level(1'b1, 16, "ready pulses");
    for (n = 0; n < pulses; n++) begin
      repeat (100) @(posedge clk);
      img_ready <= 1'b1;
      @(posedge clk);
      img_ready <= 1'b0;
    end
  endtask

  task automatic test_reset_state();
    int n;
    for (n = 0; n < 50; n++) begin
      @(negedge clk);
      assert (tx === 1'b1 && busy === 1'b0 && out_state === 2'd0) else
        log_mismatch($sformatf("idle after reset: tx %b busy %b out_state %0d",
                               tx, busy, out_state));
    end
  endtask

  task automatic test_whole_image();
    load_image(0);
    start_send();
    receive_image("ramp", 1'b1);
  endtask

  task automatic test_frame_format();
    load_image(1); // mostly alternating bits expose a short bit period
    start_send();
    receive_image("format", 1'b1);
  endtask

  task automatic test_locked_writes();
    start_send();
    fork
      receive_image("locked send", 1'b0);
      overwrite_while_busy();
    join
    start_send();
    receive_image("send after locked writes", 1'b1);
  endtask

  task automatic test_ready_ignored();
    start_send();
    fork
      receive_image("ready pulses", 1'b1);
      pulse_ready_while_busy(5);
    join
  endtask

  task automatic test_random_back_to_back();
    load_image(2);
    start_send();
    receive_image("random pass 1", 1'b0);
    start_send();
    receive_image("random pass 2", 1'b1);
  endtask

  initial begin
    rst_in    = 1'b1;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    img_ready = 1'b0;
    repeat (10) @(posedge clk);
    rst_in <= 1'b0;

    test_reset_state();
    test_whole_image();
    test_frame_format();
    test_locked_writes();
    test_ready_ignored();
    test_random_back_to_back();

    $display("summary: %0d check errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/img_tx_top.sv ====
`timescale 1ns/1ps
`include "img_tx_settings.svh"

module img_tx_top (
  input  logic              clk,
  input  logic              rst_in,
  input  logic              wr_en,
  input  logic [`ADDR_W-1:0] wr_addr,
  input  logic [7:0]        wr_data,
  input  logic              img_ready,
  output logic              tx,
  output logic              busy,
  output logic [1:0]        out_state
);

  import img_tx_pkg::*;

  pixel_t rd_data; // buffer output into the serializer
  logic   start;
  logic   lock;
  logic   done;

  scan_ctrl_if ctrl_bus ();

  frame_buffer frame_buffer_inst (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .lock    (lock),
    .rd_addr (ctrl_bus.addr),
    .rd_data (rd_data)
  );

  pixel_addr_counter pixel_addr_counter_inst (
    .clk    (clk),
    .rst_in (rst_in),
    .ctrl   (ctrl_bus.counter)
  );

  send_img_fsm send_img_fsm_inst (
    .clk       (clk),
    .rst_in    (rst_in),
    .img_ready (img_ready),
    .ctrl      (ctrl_bus.fsm),
    .done      (done),
    .start     (start),
    .lock      (lock),
    .busy      (busy),
    .out_state (out_state)
  );

  uart_tx uart_tx_inst (
    .clk    (clk),
    .rst_in (rst_in),
    .data   (rd_data),
    .start  (start),
    .done   (done),
    .tx     (tx)
  );

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`include "img_tx_settings.svh"

module uart_tx (
  input  logic               clk,
  input  logic               rst_in,
  input  img_tx_pkg::pixel_t data,
  input  logic               start,
  output logic               done,
  output logic               tx
);

  import img_tx_pkg::*;

  localparam int FRAME_BITS = $bits(pixel_t) + 2; // start + data + stop
  localparam int BAUD_W     = $clog2(`CLOCKS_PER_BAUD);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`CLOCKS_PER_BAUD - 1);
  localparam logic [3:0] BIT_LAST = 4'(FRAME_BITS - 1);

  logic                  active;
  logic [BAUD_W-1:0]     baud_cnt;
  logic [3:0]            bit_cnt;
  logic [FRAME_BITS-1:0] shreg;

  always_ff @(posedge clk) begin
    if (rst_in) begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!active) begin
      if (start) begin
        active   <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (baud_cnt == BAUD_LAST) begin
      baud_cnt <= '0;
      if (bit_cnt == BIT_LAST) begin
        active <= 1'b0; // stop bit finished
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // frame shifts out LSB first, start bit sits in bit 0
  always_ff @(posedge clk) begin
    if (!active && start) begin
      shreg <= {1'b1, data, 1'b0};
    end else if (active && baud_cnt == BAUD_LAST) begin
      shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
    end
  end

  assign done = !active;
  assign tx   = active ? shreg[0] : 1'b1; // idle line is high

endmodule

// ==== logic/send_img_fsm.sv ====
`timescale 1ns/1ps

module send_img_fsm (
  input  logic                    clk,
  input  logic                    rst_in,
  input  logic                    img_ready,
  scan_ctrl_if.fsm                ctrl,
  input  logic                    done,
  output logic                    start,
  output logic                    lock,
  output logic                    busy,
  output img_tx_pkg::scan_state_t out_state
);

  import img_tx_pkg::*;

  scan_state_t state;
  scan_state_t state_next;

  always_ff @(posedge clk) begin
    if (rst_in) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (img_ready) begin
          state_next = WAITING;
        end
      end
      WAITING: begin
        if (ctrl.data_ready) begin
          state_next = TRANSMITTING; // start goes out this cycle
        end
      end
      TRANSMITTING: begin
        // done comes back high once the stop bit is over
        if (done) begin
          state_next = ctrl.last ? IDLE : WAITING;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // one clear per image, one start and one advance per pixel
  assign ctrl.clear   = (state == IDLE) && img_ready;
  assign start        = (state == WAITING) && ctrl.data_ready;
  assign ctrl.advance = (state == TRANSMITTING) && done && !ctrl.last;

  assign busy      = (state != IDLE);
  assign lock      = (state != IDLE); // buffer frozen for the whole scan
  assign out_state = state;

endmodule

// ==== logic/pixel_addr_counter.sv ====
`timescale 1ns/1ps
`include "img_tx_settings.svh"

module pixel_addr_counter (
  input  logic           clk,
  input  logic           rst_in,
  scan_ctrl_if.counter   ctrl
);

  import img_tx_pkg::*;

  localparam int TIMER_W = $clog2(`RD_LATENCY + 1);
  localparam logic [TIMER_W-1:0] WAIT_DONE = TIMER_W'(`RD_LATENCY);
  localparam addr_t LAST_ADDR = addr_t'(`IMG_PIXELS - 1);

  addr_t              addr_q;
  logic [TIMER_W-1:0] wait_cnt;

  always_ff @(posedge clk) begin
    if (rst_in) begin
      addr_q   <= '0;
      wait_cnt <= '0;
    end else if (ctrl.clear) begin
      addr_q   <= '0;
      wait_cnt <= '0;
    end else if (ctrl.advance) begin
      addr_q   <= addr_q + 1'b1;
      wait_cnt <= '0;
    end else if (wait_cnt != WAIT_DONE) begin
      wait_cnt <= wait_cnt + 1'b1; // holds at WAIT_DONE
    end
  end

  // timer starts at zero on the cycle the new address appears,
  // so it reaches WAIT_DONE just as the buffer output catches up
  assign ctrl.addr       = addr_q;
  assign ctrl.data_ready = (wait_cnt == WAIT_DONE);
  assign ctrl.last       = (addr_q == LAST_ADDR);

endmodule

// ==== logic/frame_buffer.sv ====
`timescale 1ns/1ps
`include "img_tx_settings.svh"

module frame_buffer (
  input  logic               clk,
  input  logic               wr_en,
  input  img_tx_pkg::addr_t  wr_addr,
  input  img_tx_pkg::pixel_t wr_data,
  input  logic               lock,
  input  img_tx_pkg::addr_t  rd_addr,
  output img_tx_pkg::pixel_t rd_data
);

  import img_tx_pkg::*;

  pixel_t mem [`IMG_PIXELS];
  addr_t  rd_addr_q;

  // write port, held off while a scan is running
  always_ff @(posedge clk) begin
    if (wr_en && !lock) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // two-stage read: address register, then output register
  always_ff @(posedge clk) begin
    rd_addr_q <= rd_addr;
    rd_data   <= mem[rd_addr_q];
  end

endmodule

// ==== logic/scan_ctrl_if.sv ====
`timescale 1ns/1ps

interface scan_ctrl_if;

  logic                clear;      // zero the address, restart wait
  logic                advance;    // next address, restart wait
  img_tx_pkg::addr_t   addr;       // current pixel address
  logic                data_ready; // read latency has passed
  logic                last;       // addr is the final pixel

  modport fsm (
    output clear,
    output advance,
    input  data_ready,
    input  last
  );

  modport counter (
    input  clear,
    input  advance,
    output addr,
    output data_ready,
    output last
  );

endinterface

// ==== logic/img_tx_pkg.sv ====
`include "img_tx_settings.svh"

package img_tx_pkg;

  // scan sequence, two bits so it can go straight out as out_state
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    WAITING      = 2'd1,
    TRANSMITTING = 2'd2
  } scan_state_t;

  typedef logic [7:0] pixel_t; // one image byte

  typedef logic [`ADDR_W-1:0] addr_t; // frame buffer address

endpackage

// ==== logic/img_tx_settings.svh ====
`ifndef IMG_TX_SETTINGS_SVH
`define IMG_TX_SETTINGS_SVH

// image size in bytes, 16384 for the full frame
`define IMG_PIXELS 16

// must equal log2 of IMG_PIXELS
`define ADDR_W 4

// clock cycles per serial bit
`define CLOCKS_PER_BAUD 8

// frame buffer read latency, matches the two-stage read
`define RD_LATENCY 2

`endif
